// ==== common/cciPkg.sv ====
// ======================================
// Shared definitions for the host-memory driver front block
// Line and tag widths, request and response channel structs,
// CSR indices and the CSR state seen by the tap
// ======================================

`default_nettype none

package cciPkg;

    // Width of one cache line of write data
    localparam int LineBits = 128;

    // Line address width, with no virtual addressing
    localparam int AddrBits = 32;

    // Request tag carried back in the write response
    localparam int MdataBits = 16;

    // MMIO data is one 64-bit word
    localparam int MmioDataBits = 64;

    // Only write-line requests are generated, read-line is kept for the field meaning
    typedef enum logic [0:0] {
        reqRdLine = 1'b0,
        reqWrLine = 1'b1
    } reqTypeE;

    typedef struct packed {
        reqTypeE                reqType;
        logic [AddrBits-1:0]    addr;
        logic [MdataBits-1:0]   mdata;
    } reqHdrT;

    // Write-request channel toward the host
    typedef struct packed {
        logic                   wrValid;
        reqHdrT                 hdr;
        logic [LineBits-1:0]    data;
    } c1TxT;

    // Write-response channel from the host
    typedef struct packed {
        logic                   wrValid;
        logic [MdataBits-1:0]   mdata;
    } wrRspT;

    // CSR indices, anything else reads as zero
    typedef enum logic [3:0] {
        dsmBase  = 4'd0,
        scratch  = 4'd1,
        afuIdLow = 4'd2
    } csrIndexE;

    // MMIO request from the host, at most one of the valids is set
    typedef struct packed {
        logic                       wrValid;
        logic                       rdValid;
        csrIndexE                   index;
        logic [7:0]                 tid;
        logic [MmioDataBits-1:0]    data;
    } mmioReqT;

    typedef struct packed {
        logic                       rdValid;
        logic [7:0]                 tid;
        logic [MmioDataBits-1:0]    data;
    } mmioRspT;

    // CSR state that the tap watches
    typedef struct packed {
        logic [AddrBits-1:0]    dsmBase;
        logic                   dsmBaseValid;
    } csrStateT;

endpackage

`default_nettype wire

// ==== driver/driverCsr.sv ====
// ======================================
// driverCsr: host MMIO decode
// Holds the DSM base, its valid bit and a scratch word,
// answers each MMIO read one cycle later
// ======================================

`default_nettype none

module driverCsr
#(
    // Identifier of the accelerator, the low word is readable over MMIO
    parameter logic [cciPkg::LineBits-1:0] AfuId = '0
)
(
    input  logic                clk,
    input  logic                reset,

    input  cciPkg::mmioReqT     mmioReq,
    output cciPkg::mmioRspT     mmioRsp,

    output cciPkg::csrStateT    csrState
);

    // Free read/write word for software
    logic [cciPkg::MmioDataBits-1:0] scratchReg;

    // Value of the register addressed by the current read
    logic [cciPkg::MmioDataBits-1:0] rdData;

    // Read mux over the CSR index
    always_comb
    begin
        case (mmioReq.index)
            cciPkg::dsmBase:
            begin
                rdData = cciPkg::MmioDataBits'(csrState.dsmBase);
            end
            cciPkg::scratch:
            begin
                rdData = scratchReg;
            end
            cciPkg::afuIdLow:
            begin
                rdData = AfuId[cciPkg::MmioDataBits-1:0];
            end
            default:
            begin
                // Unmapped index
                rdData = '0;
            end
        endcase
    end

    // Register writes land in the cycle after the request
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            csrState.dsmBaseValid <= 1'b0;
        end
        else if (mmioReq.wrValid)
        begin
            case (mmioReq.index)
                cciPkg::dsmBase:
                begin
                    // Only the low line-address bits are kept
                    csrState.dsmBase      <= mmioReq.data[cciPkg::AddrBits-1:0];
                    // Stays set until the next reset
                    csrState.dsmBaseValid <= 1'b1;
                end
                cciPkg::scratch:
                begin
                    scratchReg <= mmioReq.data;
                end
                default:
                begin
                    // The AFU ID is read-only, other indices are ignored
                end
            endcase
        end
    end

    // One response per read request, with the request's tid
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            mmioRsp.rdValid <= 1'b0;
        end
        else
        begin
            mmioRsp.rdValid <= mmioReq.rdValid;
            mmioRsp.tid     <= mmioReq.tid;
            mmioRsp.data    <= rdData;
        end
    end

    // Host issues either a write or a read in one cycle, never both
    assert property (@(posedge clk) disable iff (reset)
        !(mmioReq.wrValid && mmioReq.rdValid));

endmodule

`default_nettype wire

// ==== driver/fiuTap.sv ====
// ======================================
// fiuTap: tap on the host write channels
// Forwards AFU writes, injects the DSM writes into idle slots,
// filters write responses carrying the driver tag
// ======================================

`default_nettype none

module fiuTap
#(
    parameter logic [cciPkg::LineBits-1:0]  AfuId      = '0,
    // Mdata of every injected write, its responses never reach the AFU
    parameter logic [cciPkg::MdataBits-1:0] WriteTag   = '1,
    // Send MMIO read results as a write to DSM line 1
    parameter bit                           MmioViaDsm = 1'b1
)
(
    input  logic                clk,
    input  logic                reset,

    input  cciPkg::c1TxT        afuTx,
    output cciPkg::c1TxT        hostTx,

    input  logic                hostAlmFull,
    output logic                afuAlmFull,

    input  cciPkg::wrRspT       hostRsp0,
    input  cciPkg::wrRspT       hostRsp1,
    output cciPkg::wrRspT       afuRsp0,
    output cciPkg::wrRspT       afuRsp1,

    input  cciPkg::csrStateT    csrState,
    input  cciPkg::mmioRspT     mmioRsp,
    output cciPkg::mmioRspT     hostMmioRsp
);

    // Set once the AFU ID has gone out to DSM line 0
    logic afuIdWritten;

    // One-entry holding register for an MMIO read result
    cciPkg::mmioRspT heldRsp;

    logic injSlot;
    logic sendAfuId;
    logic sendHeld;

    // A slot is free when the host has room and the AFU is silent
    assign injSlot   = !hostAlmFull && !afuTx.wrValid;
    assign sendAfuId = injSlot && csrState.dsmBaseValid && !afuIdWritten;
    // The AFU ID write goes first when both are pending
    assign sendHeld  = injSlot && heldRsp.rdValid && !sendAfuId;

    assign afuAlmFull = hostAlmFull;

    // Drops a response that answers one of the injected writes
    function automatic cciPkg::wrRspT filterRsp(input cciPkg::wrRspT rsp);
        cciPkg::wrRspT res;
        res = rsp;
        if (rsp.mdata == WriteTag)
        begin
            res.wrValid = 1'b0;
        end
        return res;
    endfunction

    assign afuRsp0 = filterRsp(hostRsp0);
    assign afuRsp1 = filterRsp(hostRsp1);

    always_comb
    begin
        // AFU traffic passes through unchanged by default
        hostTx = afuTx;

        if (sendAfuId)
        begin
            hostTx.wrValid = 1'b1;
            hostTx.hdr     = '{reqType: cciPkg::reqWrLine,
                               addr:    csrState.dsmBase,
                               mdata:   WriteTag};
            hostTx.data    = AfuId;
        end
        else if (sendHeld)
        begin
            hostTx.wrValid = 1'b1;
            hostTx.hdr     = '{reqType: cciPkg::reqWrLine,
                               addr:    csrState.dsmBase + cciPkg::AddrBits'(1),
                               mdata:   WriteTag};
            hostTx.data    = '0;
            hostTx.data[cciPkg::MmioDataBits-1:0] = heldRsp.data;
            // Bit 64 tells software that the line was written
            hostTx.data[64] = 1'b1;
        end
    end

    // In compatibility mode the result only reaches software through DSM
    always_comb
    begin
        hostMmioRsp = mmioRsp;
        if (MmioViaDsm)
        begin
            hostMmioRsp.rdValid = 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            afuIdWritten <= 1'b0;
        end
        else if (sendAfuId)
        begin
            afuIdWritten <= 1'b1;
        end
    end

    // Capture a read result, release it in the cycle it is sent
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            heldRsp.rdValid <= 1'b0;
        end
        else if (MmioViaDsm && mmioRsp.rdValid)
        begin
            heldRsp <= mmioRsp;
        end
        else if (sendHeld)
        begin
            heldRsp.rdValid <= 1'b0;
        end
    end

    // Software waits for each result, so the register is empty when the next arrives
    assert property (@(posedge clk) disable iff (reset)
        (MmioViaDsm && mmioRsp.rdValid) |-> !heldRsp.rdValid);

    // A tagged write on the host side is always ours and must sit in a free slot
    assert property (@(posedge clk) disable iff (reset)
        (hostTx.wrValid && hostTx.hdr.mdata == WriteTag) |-> (!afuTx.wrValid && !hostAlmFull));

endmodule

`default_nettype wire

// ==== source/qaDriverTop.sv ====
// ======================================
// qaDriverTop: driver front block
// Joins the CSR decode and the host channel tap
// ======================================

`default_nettype none

module qaDriverTop
#(
    parameter logic [cciPkg::LineBits-1:0]  AfuId      = '0,
    parameter logic [cciPkg::MdataBits-1:0] WriteTag   = '1,
    parameter bit                           MmioViaDsm = 1'b1
)
(
    input  logic                clk,
    input  logic                reset,

    // Host side
    input  cciPkg::mmioReqT     hostMmio,
    output cciPkg::mmioRspT     hostMmioRsp,
    input  logic                hostAlmFull,
    input  cciPkg::wrRspT       hostRsp0,
    input  cciPkg::wrRspT       hostRsp1,
    output cciPkg::c1TxT        hostTx,

    // AFU side
    input  cciPkg::c1TxT        afuTx,
    output logic                afuAlmFull,
    output cciPkg::wrRspT       afuRsp0,
    output cciPkg::wrRspT       afuRsp1
);

    // CSR state and raw read responses feeding the tap
    cciPkg::csrStateT csrState;
    cciPkg::mmioRspT  mmioRsp;

    driverCsr #(
        .AfuId      (AfuId)
    ) driverCsrInst (
        .clk        (clk),
        .reset      (reset),
        .mmioReq    (hostMmio),
        .mmioRsp    (mmioRsp),
        .csrState   (csrState)
    );

    // The tap owns every host and AFU output
    fiuTap #(
        .AfuId       (AfuId),
        .WriteTag    (WriteTag),
        .MmioViaDsm  (MmioViaDsm)
    ) fiuTapInst (
        .clk         (clk),
        .reset       (reset),
        .afuTx       (afuTx),
        .hostTx      (hostTx),
        .hostAlmFull (hostAlmFull),
        .afuAlmFull  (afuAlmFull),
        .hostRsp0    (hostRsp0),
        .hostRsp1    (hostRsp1),
        .afuRsp0     (afuRsp0),
        .afuRsp1     (afuRsp1),
        .csrState    (csrState),
        .mmioRsp     (mmioRsp),
        .hostMmioRsp (hostMmioRsp)
    );

endmodule

`default_nettype wire

// ==== tests/tbQaDriver.sv ====
// ========================================
// Testbench for the driver front block
// Clock, reset, xorshift stimulus, reference model,
// compare tasks and a scoreboard on the host write channel
// ========================================

`default_nettype none

module tbQaDriver;

    localparam logic [cciPkg::LineBits-1:0] AfuId = 128'h0123_4567_89ab_cdef_fedc_ba98_7654_3210;
    localparam logic [cciPkg::MdataBits-1:0] WriteTag = 16'hffff;
    localparam logic [31:0] Seed = 32'hb06bb997;
    // Longest wait for one injected write under idle inputs
    localparam int WaitLimit = 50;

    logic clk;
    logic reset;
    cciPkg::mmioReqT hostMmio;
    cciPkg::mmioRspT hostMmioRsp;
    logic hostAlmFull;
    cciPkg::wrRspT hostRsp0;
    cciPkg::wrRspT hostRsp1;
    cciPkg::c1TxT hostTx;
    cciPkg::c1TxT afuTx;
    logic afuAlmFull;
    cciPkg::wrRspT afuRsp0;
    cciPkg::wrRspT afuRsp1;

    logic [31:0] rngState;

    // Software view of the CSRs
    logic [cciPkg::AddrBits-1:0] dsmBaseModel;
    logic [cciPkg::MmioDataBits-1:0] scratchModel;
    bit baseWritten;

    // AFU writes in flight and injected writes still to come
    cciPkg::c1TxT afuQ[$];
    cciPkg::c1TxT injQ[$];

    qaDriverTop #(
        .AfuId      (AfuId),
        .WriteTag   (WriteTag),
        .MmioViaDsm (1'b1)
    ) qaDriverTop_inst (
        .clk         (clk),
        .reset       (reset),
        .hostMmio    (hostMmio),
        .hostMmioRsp (hostMmioRsp),
        .hostAlmFull (hostAlmFull),
        .hostRsp0    (hostRsp0),
        .hostRsp1    (hostRsp1),
        .hostTx      (hostTx),
        .afuTx       (afuTx),
        .afuAlmFull  (afuAlmFull),
        .afuRsp0     (afuRsp0),
        .afuRsp1     (afuRsp1)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] nextRand();
        rngState = xorshift(rngState);
        return rngState;
    endfunction

    // Value software expects to read back from a CSR index
    function automatic logic [63:0] csrModelRead(input cciPkg::csrIndexE index);
        case (index)
            cciPkg::dsmBase:  return 64'(dsmBaseModel);
            cciPkg::scratch:  return scratchModel;
            cciPkg::afuIdLow: return AfuId[63:0];
            default:          return 64'h0;
        endcase
    endfunction

    // Expected DSM write: line 0 gets the AFU ID, line 1 gets a read result with bit 64 set
    function automatic cciPkg::c1TxT expectedDsmWrite(input logic [31:0] base,
                                                      input bit isResult,
                                                      input logic [63:0] value);
        cciPkg::c1TxT t;
        t = '0;
        t.wrValid = 1'b1;
        t.hdr.reqType = cciPkg::reqWrLine;
        t.hdr.mdata = WriteTag;
        if (isResult)
        begin
            t.hdr.addr = base + 32'd1;
            t.data[63:0] = value;
            t.data[64] = 1'b1;
        end
        else
        begin
            t.hdr.addr = base;
            t.data = AfuId;
        end
        return t;
    endfunction

    // Tagged responses belong to the driver and never reach the AFU
    function automatic cciPkg::wrRspT expectedRsp(input cciPkg::wrRspT rsp);
        cciPkg::wrRspT r;
        r = rsp;
        if (rsp.mdata == WriteTag)
        begin
            r.wrValid = 1'b0;
        end
        return r;
    endfunction

    task automatic abortRun();
        $display("Result: FAILED");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic failMismatch(input string msg);
        $display("Fail at time %0t: %s", $time, msg);
        abortRun();
    endtask

    task automatic checkTx(input cciPkg::c1TxT actual, input cciPkg::c1TxT expected,
                           input string what);
        if (actual !== expected)
        begin
            failMismatch($sformatf("%s got %h expected %h", what, actual, expected));
        end
    endtask

    task automatic checkRsp(input cciPkg::wrRspT actual, input cciPkg::wrRspT expected,
                            input string what);
        if (actual !== expected)
        begin
            failMismatch($sformatf("%s got %h expected %h", what, actual, expected));
        end
    endtask

    // Only the valid bit matters when no response is expected
    task automatic checkMmio(input cciPkg::mmioRspT actual, input cciPkg::mmioRspT expected,
                             input string what);
        if (actual.rdValid !== expected.rdValid)
        begin
            failMismatch($sformatf("%s valid is %b", what, actual.rdValid));
        end
        else if (expected.rdValid && (actual !== expected))
        begin
            failMismatch($sformatf("%s got %h expected %h", what, actual, expected));
        end
    endtask

    task automatic driveIdle();
        afuTx = '0;
        hostAlmFull = 1'b0;
        hostRsp0 = '0;
        hostRsp1 = '0;
        hostMmio = '0;
    endtask

    task automatic mmioWrite(input cciPkg::csrIndexE index, input logic [63:0] data);
        @(negedge clk);
        hostMmio = '0;
        hostMmio.wrValid = 1'b1;
        hostMmio.index = index;
        hostMmio.data = data;
        if (index == cciPkg::dsmBase)
        begin
            dsmBaseModel = data[31:0];
            // Only the first base write brings the AFU ID out
            if (!baseWritten)
            begin
                injQ.push_back(expectedDsmWrite(data[31:0], 1'b0, 64'h0));
            end
            baseWritten = 1'b1;
        end
        else if (index == cciPkg::scratch)
        begin
            scratchModel = data;
        end
        @(negedge clk);
        hostMmio = '0;
    endtask

    task automatic issueRead(input cciPkg::csrIndexE index);
        logic [31:0] r;
        @(negedge clk);
        r = nextRand();
        hostMmio = '0;
        hostMmio.rdValid = 1'b1;
        hostMmio.index = index;
        hostMmio.tid = r[7:0];
        injQ.push_back(expectedDsmWrite(dsmBaseModel, 1'b1, csrModelRead(index)));
        @(negedge clk);
        hostMmio = '0;
    endtask

    task automatic waitInjected(input string what);
        int cycles;
        cycles = 0;
        while (injQ.size() != 0 && cycles < WaitLimit)
        begin
            @(negedge clk);
            cycles++;
        end
        if (injQ.size() != 0)
        begin
            $display("Timed out at %0t waiting for the %s", $time, what);
            abortRun();
        end
    endtask

    function automatic cciPkg::wrRspT randomRsp();
        cciPkg::wrRspT rsp;
        logic [31:0] r;
        r = nextRand();
        rsp.wrValid = r[0];
        // About one in eight responses carries the driver tag
        rsp.mdata = (r[3:1] == 3'd0) ? WriteTag : r[31:16];
        return rsp;
    endfunction

    // Levels are out of 8 and set how often the AFU writes and almost-full is high
    task automatic randomTraffic(input int cycles, input int afuLevel, input int almLevel);
        logic [31:0] r;
        cciPkg::c1TxT tx;
        for (int i = 0; i < cycles; i++)
        begin
            @(negedge clk);
            r = nextRand();
            tx = '0;
            if (int'(r[2:0]) < afuLevel)
            begin
                tx.wrValid = 1'b1;
                tx.hdr.reqType = cciPkg::reqWrLine;
                tx.hdr.addr = nextRand();
                tx.hdr.mdata = (r[31:16] == WriteTag) ? 16'h1234 : r[31:16];
                tx.data = {nextRand(), nextRand(), nextRand(), nextRand()};
                afuQ.push_back(tx);
            end
            afuTx = tx;
            hostAlmFull = int'(r[5:3]) < almLevel;
            hostRsp0 = randomRsp();
            hostRsp1 = randomRsp();
        end
        @(negedge clk);
        driveIdle();
    endtask

    // Scoreboard on the host side, sampled before the registers move
    always @(posedge clk)
    begin
        cciPkg::c1TxT expTx;
        if (!reset)
        begin
            if (afuAlmFull !== hostAlmFull)
            begin
                failMismatch("afuAlmFull differs from hostAlmFull");
            end
            checkRsp(afuRsp0, expectedRsp(hostRsp0), "afuRsp0");
            checkRsp(afuRsp1, expectedRsp(hostRsp1), "afuRsp1");
            checkMmio(hostMmioRsp, '0, "hostMmioRsp");
            if (hostTx.wrValid === 1'b1 && hostTx.hdr.mdata == WriteTag)
            begin
                if (afuTx.wrValid || hostAlmFull)
                begin
                    failMismatch("injected write outside an injection slot");
                end
                else if (injQ.size() == 0)
                begin
                    failMismatch($sformatf("unexpected injected write %h", hostTx));
                end
                else
                begin
                    expTx = injQ.pop_front();
                    checkTx(hostTx, expTx, "injected DSM write");
                end
            end
            else if (afuTx.wrValid)
            begin
                expTx = afuQ.pop_front();
                checkTx(hostTx, expTx, "AFU pass-through write");
            end
            else if (hostTx.wrValid !== 1'b0)
            begin
                failMismatch("hostTx valid with no source");
            end
        end
    end

    initial
    begin
        rngState = Seed;
        clk = 1'b0;
        reset = 1'b1;
        baseWritten = 1'b0;
        dsmBaseModel = '0;
        scratchModel = '0;
        driveIdle();
        repeat (3) @(negedge clk);
        reset = 1'b0;

        // Nothing may leave the tap before software sets the base
        randomTraffic(20, 0, 3);

        // AFU ID write held back by AFU traffic and almost-full
        // Almost-full is already high when the base lands, so the first free slot comes later
        hostAlmFull = 1'b1;
        mmioWrite(cciPkg::dsmBase, {nextRand(), nextRand()});
        randomTraffic(30, 4, 2);
        waitInjected("AFU ID write");
        mmioWrite(cciPkg::dsmBase, {nextRand(), nextRand()});
        randomTraffic(10, 0, 0);

        // Read every CSR plus one unmapped index
        mmioWrite(cciPkg::scratch, {nextRand(), nextRand()});
        issueRead(cciPkg::dsmBase);
        waitInjected("DSM base read result");
        issueRead(cciPkg::scratch);
        waitInjected("scratch read result");
        issueRead(cciPkg::afuIdLow);
        waitInjected("AFU ID read result");
        issueRead(cciPkg::csrIndexE'(4'd7));
        waitInjected("unmapped read result");

        // Read result competing with heavy AFU traffic
        mmioWrite(cciPkg::scratch, {nextRand(), nextRand()});
        issueRead(cciPkg::scratch);
        randomTraffic(40, 6, 3);
        waitInjected("read result after traffic");
        randomTraffic(40, 3, 2);

        if (afuQ.size() != 0 || injQ.size() != 0)
        begin
            $display("Writes never reached the host: %0d AFU, %0d injected",
                     afuQ.size(), injQ.size());
            abortRun();
        end
        else
        begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
common/cciPkg.sv
driver/driverCsr.sv
driver/fiuTap.sv
source/qaDriverTop.sv
tests/tbQaDriver.sv

// ==== Bender.yml ====
package:
  name: qa_driver

sources:
  - common/cciPkg.sv
  - driver/driverCsr.sv
  - driver/fiuTap.sv
  - source/qaDriverTop.sv
  - target: test
    files:
      - tests/tbQaDriver.sv
